// ==== rtl/mmioPkg.sv ====
package mmioPkg;

    // --------------------------------------------------
    // widths that carry a meaning
    // --------------------------------------------------
    typedef logic [31:0] tWord;    // data word
    typedef logic [31:0] tAddr;    // request address
    typedef logic [1:0]  tOpcode;  // request / response kind
    typedef logic [1:0]  tRegion;  // address[23:22]
    typedef logic [6:0]  tSeg;     // one 7-seg digit, active segments
    typedef logic [9:0]  tLed;
    typedef logic [9:0]  tSwitch;
    typedef logic [3:0]  tColor;   // one vga channel

    // opcodes on the fabric-to-core port
    localparam tOpcode opRd    = 2'b00;
    localparam tOpcode opWr    = 2'b01;
    localparam tOpcode opRdRsp = 2'b10;  // answer to reads and writes alike

    // region field position and codes
    localparam int     regionMsb   = 23;
    localparam int     regionLsb   = 22;
    localparam tRegion regionFrame = 2'b01;  // vga pixel memory
    localparam tRegion regionCr    = 2'b10;  // control registers

    // --------------------------------------------------
    // control register offsets, byte addressed
    // --------------------------------------------------
    localparam int          crOffMsb   = 19;  // offsets live in address[19:0]
    localparam logic [19:0] offSeg0    = 20'h00000;
    localparam logic [19:0] offSeg1    = 20'h00004;
    localparam logic [19:0] offSeg2    = 20'h00008;
    localparam logic [19:0] offSeg3    = 20'h0000C;
    localparam logic [19:0] offSeg4    = 20'h00010;
    localparam logic [19:0] offSeg5    = 20'h00014;
    localparam logic [19:0] offLed     = 20'h00018;
    localparam logic [19:0] offButton0 = 20'h0001C;  // read only
    localparam logic [19:0] offButton1 = 20'h00020;  // read only
    localparam logic [19:0] offSwitch  = 20'h00024;  // read only

    // frame word packing, lowest nibble is shown first
    localparam int pixPerWord = 8;

endpackage

// ==== rtl/mmioCtrl.sv ====
`timescale 1ns/1ps

module mmioCtrl (
    input  logic            QClk,
    input  logic            rstN,
    input  logic            reqValid,
    input  mmioPkg::tOpcode reqOpcode,
    input  mmioPkg::tAddr   reqAddress,
    input  mmioPkg::tWord   reqData,
    input  mmioPkg::tWord   crRdData,     // combinational, stage A
    input  mmioPkg::tWord   frameRdData,  // registered, valid in stage B
    output logic            crRd,
    output logic            crWr,
    output logic            frameRd,
    output logic            frameWr,
    output mmioPkg::tAddr   accAddress,
    output mmioPkg::tWord   accData,
    output logic            rspValid,
    output mmioPkg::tOpcode rspOpcode,
    output mmioPkg::tAddr   rspAddress,
    output mmioPkg::tWord   rspData
);
    import mmioPkg::*;

    logic   validA;
    tOpcode opcodeA;
    tAddr   addressA;
    tWord   dataA;
    tRegion regionA;
    logic   crRdB;
    logic   crWrB;
    logic   frameRdB;
    logic   frameWrB;
    tAddr   addressB;
    tWord   crDataB;
    tWord   rspDataB;

    // --------------------------------------------------
    // stage A, sample the request
    // --------------------------------------------------
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            validA <= 1'b0;
        end else begin
            validA <= reqValid;
        end
    end

    always_ff @(posedge QClk) begin
        opcodeA  <= reqOpcode;
        addressA <= reqAddress;
        dataA    <= reqData;
    end

    // region and opcode decode, only place they are tested
    assign regionA = addressA[regionMsb:regionLsb];
    assign crRd    = validA && (opcodeA == opRd) && (regionA == regionCr);
    assign crWr    = validA && (opcodeA == opWr) && (regionA == regionCr);
    assign frameRd = validA && (opcodeA == opRd) && (regionA == regionFrame);
    assign frameWr = validA && (opcodeA == opWr) && (regionA == regionFrame);

    assign accAddress = addressA;  // offset decode done by the datapath blocks
    assign accData    = dataA;

    // --------------------------------------------------
    // stage B, align cr data with the frame memory latency
    // --------------------------------------------------
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            crRdB    <= 1'b0;
            crWrB    <= 1'b0;
            frameRdB <= 1'b0;
            frameWrB <= 1'b0;
        end else begin
            crRdB    <= crRd;
            crWrB    <= crWr;
            frameRdB <= frameRd;
            frameWrB <= frameWr;
        end
    end

    always_ff @(posedge QClk) begin
        addressB <= addressA;
        crDataB  <= crRdData;
    end

    // write responses carry zero
    assign rspDataB = crRdB    ? crDataB     :
                      frameRdB ? frameRdData :
                                 '0;

    // stage C, response out
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= crRdB || crWrB || frameRdB || frameWrB;  // unmapped drops out
        end
    end

    always_ff @(posedge QClk) begin
        rspOpcode  <= opRdRsp;
        rspAddress <= addressB;
        rspData    <= rspDataB;
    end

endmodule

// ==== rtl/crRegs.sv ====
`timescale 1ns/1ps

module crRegs (
    input  logic            QClk,
    input  logic            rstN,
    input  logic            crRd,
    input  logic            crWr,
    input  mmioPkg::tAddr   accAddress,
    input  mmioPkg::tWord   accData,
    input  logic            button0,
    input  logic            button1,
    input  mmioPkg::tSwitch switch,
    output mmioPkg::tWord   crRdData,
    output mmioPkg::tSeg    seg0,
    output mmioPkg::tSeg    seg1,
    output mmioPkg::tSeg    seg2,
    output mmioPkg::tSeg    seg3,
    output mmioPkg::tSeg    seg4,
    output mmioPkg::tSeg    seg5,
    output mmioPkg::tLed    led
);
    import mmioPkg::*;

    logic [crOffMsb:0] crOff;
    logic              button0Q;
    logic              button1Q;
    tSwitch            switchQ;

    assign crOff = accAddress[crOffMsb:0];

    // --------------------------------------------------
    // read/write registers, drive the board directly
    // --------------------------------------------------
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            seg0 <= '0;
            seg1 <= '0;
            seg2 <= '0;
            seg3 <= '0;
            seg4 <= '0;
            seg5 <= '0;
            led  <= '0;
        end else if (crWr) begin
            case (crOff)
                offSeg0: seg0 <= tSeg'(accData);  // low bits only
                offSeg1: seg1 <= tSeg'(accData);
                offSeg2: seg2 <= tSeg'(accData);
                offSeg3: seg3 <= tSeg'(accData);
                offSeg4: seg4 <= tSeg'(accData);
                offSeg5: seg5 <= tSeg'(accData);
                offLed:  led  <= tLed'(accData);
                default: ;  // read-only and unknown offsets ignore writes
            endcase
        end
    end

    // board inputs, sampled every cycle
    always_ff @(posedge QClk) begin
        button0Q <= button0;
        button1Q <= button1;
        switchQ  <= switch;
    end

    // read mux, zero extended
    always_comb begin
        crRdData = '0;
        if (crRd) begin
            case (crOff)
                offSeg0:    crRdData = tWord'(seg0);
                offSeg1:    crRdData = tWord'(seg1);
                offSeg2:    crRdData = tWord'(seg2);
                offSeg3:    crRdData = tWord'(seg3);
                offSeg4:    crRdData = tWord'(seg4);
                offSeg5:    crRdData = tWord'(seg5);
                offLed:     crRdData = tWord'(led);
                offButton0: crRdData = tWord'(button0Q);
                offButton1: crRdData = tWord'(button1Q);
                offSwitch:  crRdData = tWord'(switchQ);
                default:    crRdData = '0;  // unmapped offset
            endcase
        end
    end

endmodule

// ==== rtl/vgaFrameMem.sv ====
`timescale 1ns/1ps

module vgaFrameMem #(
    parameter int depth = 16
) (
    input  logic                     QClk,
    input  logic                     frameRd,
    input  logic                     frameWr,
    input  mmioPkg::tAddr            accAddress,
    input  mmioPkg::tWord            accData,
    input  logic [$clog2(depth)-1:0] scanAddr,
    output mmioPkg::tWord            frameRdData,
    output mmioPkg::tWord            scanData
);
    import mmioPkg::*;

    localparam int addrW = $clog2(depth);

    tWord             mem [depth];
    logic [29:0]      wordOff;
    logic [addrW-1:0] wordIdx;

    // byte address to word index, wraps on depth
    assign wordOff = accAddress[31:2] % 30'(depth);
    assign wordIdx = wordOff[addrW-1:0];

    // --------------------------------------------------
    // processor port, one cycle read latency
    // --------------------------------------------------
    always_ff @(posedge QClk) begin
        if (frameWr) begin
            mem[wordIdx] <= accData;
        end
        if (frameRd) begin
            frameRdData <= mem[wordIdx];  // old word on collision
        end
    end

    // scan port, read only
    always_ff @(posedge QClk) begin
        scanData <= mem[scanAddr];
    end

endmodule

// ==== rtl/vgaScan.sv ====
`timescale 1ns/1ps

module vgaScan #(
    parameter int hActive  = 16,
    parameter int hFront   = 2,
    parameter int hSyncLen = 4,
    parameter int hBack    = 2,
    parameter int vActive  = 8,
    parameter int vFront   = 1,
    parameter int vSyncLen = 2,
    parameter int vBack    = 1
) (
    input  logic          QClk,
    input  logic          rstN,
    input  mmioPkg::tWord scanData,  // one cycle after scanAddr
    output logic [$clog2(hActive*vActive/mmioPkg::pixPerWord)-1:0] scanAddr,
    output mmioPkg::tColor red,
    output mmioPkg::tColor green,
    output mmioPkg::tColor blue,
    output logic           hSync,
    output logic           vSync
);
    import mmioPkg::*;

    localparam int hTotal       = hActive + hFront + hSyncLen + hBack;
    localparam int vTotal       = vActive + vFront + vSyncLen + vBack;
    localparam int hW           = $clog2(hTotal);
    localparam int vW           = $clog2(vTotal);
    localparam int addrW        = $clog2(hActive * vActive / pixPerWord);
    localparam int wordsPerLine = hActive / pixPerWord;
    localparam int hSyncStart   = hActive + hFront;
    localparam int vSyncStart   = vActive + vFront;

    logic          pixelStrobe;
    logic [hW-1:0] hCnt;
    logic [vW-1:0] vCnt;
    logic          active;
    logic          groupStart;
    tWord          pixShift;
    tColor         pixel;

    // --------------------------------------------------
    // pixel strobe and counters
    // --------------------------------------------------
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            pixelStrobe <= 1'b0;
        end else begin
            pixelStrobe <= ~pixelStrobe;  // every second cycle
        end
    end

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (pixelStrobe) begin
            if (int'(hCnt) == hTotal - 1) begin
                hCnt <= '0;
                if (int'(vCnt) == vTotal - 1) begin
                    vCnt <= '0;
                end else begin
                    vCnt <= vCnt + 1'b1;
                end
            end else begin
                hCnt <= hCnt + 1'b1;
            end
        end
    end

    assign active     = (int'(hCnt) < hActive) && (int'(vCnt) < vActive);
    assign groupStart = (int'(hCnt) % pixPerWord) == 0;  // first of eight pixels

    // word for the current group, settles a cycle before the strobe
    always_comb begin
        scanAddr = '0;
        if (active) begin
            scanAddr = addrW'(int'(vCnt) * wordsPerLine + int'(hCnt) / pixPerWord);
        end
    end

    // nibble shifter
    assign pixel = groupStart ? tColor'(scanData) : tColor'(pixShift);

    always_ff @(posedge QClk) begin
        if (pixelStrobe) begin
            pixShift <= (groupStart ? scanData : pixShift) >> $bits(tColor);
        end
    end

    // outputs registered on the strobe, blanked outside active video
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else if (pixelStrobe) begin
            red   <= active ? pixel : '0;
            green <= active ? pixel : '0;  // grey scale
            blue  <= active ? pixel : '0;
            hSync <= !((int'(hCnt) >= hSyncStart) && (int'(hCnt) < hSyncStart + hSyncLen));
            vSync <= !((int'(vCnt) >= vSyncStart) && (int'(vCnt) < vSyncStart + vSyncLen));
        end
    end

endmodule

// ==== rtl/de10LiteMmio.sv ====
`timescale 1ns/1ps

module de10LiteMmio #(
    parameter int hActive  = 16,
    parameter int hFront   = 2,
    parameter int hSyncLen = 4,
    parameter int hBack    = 2,
    parameter int vActive  = 8,
    parameter int vFront   = 1,
    parameter int vSyncLen = 2,
    parameter int vBack    = 1
) (
    input  logic            QClk,
    input  logic            rstN,
    input  logic            reqValid,
    input  mmioPkg::tOpcode reqOpcode,
    input  mmioPkg::tAddr   reqAddress,
    input  mmioPkg::tWord   reqData,
    input  logic            button0,
    input  logic            button1,
    input  mmioPkg::tSwitch switch,
    output logic            rspValid,
    output mmioPkg::tOpcode rspOpcode,
    output mmioPkg::tAddr   rspAddress,
    output mmioPkg::tWord   rspData,
    output mmioPkg::tSeg    seg0,
    output mmioPkg::tSeg    seg1,
    output mmioPkg::tSeg    seg2,
    output mmioPkg::tSeg    seg3,
    output mmioPkg::tSeg    seg4,
    output mmioPkg::tSeg    seg5,
    output mmioPkg::tLed    led,
    output mmioPkg::tColor  red,
    output mmioPkg::tColor  green,
    output mmioPkg::tColor  blue,
    output logic            hSync,
    output logic            vSync
);
    import mmioPkg::*;

    localparam int frameDepth = hActive * vActive / pixPerWord;
    localparam int scanW      = $clog2(frameDepth);

    // --------------------------------------------------
    // ctrl to datapath
    // --------------------------------------------------
    logic             crRd;
    logic             crWr;
    logic             frameRd;
    logic             frameWr;
    tAddr             accAddress;
    tWord             accData;
    tWord             crRdData;
    tWord             frameRdData;
    logic [scanW-1:0] scanAddr;   // scan engine side
    tWord             scanData;

    mmioCtrl ctrl (
        .QClk        (QClk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .reqOpcode   (reqOpcode),
        .reqAddress  (reqAddress),
        .reqData     (reqData),
        .crRdData    (crRdData),
        .frameRdData (frameRdData),
        .crRd        (crRd),
        .crWr        (crWr),
        .frameRd     (frameRd),
        .frameWr     (frameWr),
        .accAddress  (accAddress),
        .accData     (accData),
        .rspValid    (rspValid),
        .rspOpcode   (rspOpcode),
        .rspAddress  (rspAddress),
        .rspData     (rspData)
    );

    crRegs cr (
        .QClk       (QClk),
        .rstN       (rstN),
        .crRd       (crRd),
        .crWr       (crWr),
        .accAddress (accAddress),
        .accData    (accData),
        .button0    (button0),
        .button1    (button1),
        .switch     (switch),
        .crRdData   (crRdData),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5),
        .led        (led)
    );

    vgaFrameMem #(
        .depth (frameDepth)
    ) frameMem (
        .QClk        (QClk),
        .frameRd     (frameRd),
        .frameWr     (frameWr),
        .accAddress  (accAddress),
        .accData     (accData),
        .scanAddr    (scanAddr),
        .frameRdData (frameRdData),
        .scanData    (scanData)
    );

    // timing passed down unchanged
    vgaScan #(
        .hActive  (hActive),
        .hFront   (hFront),
        .hSyncLen (hSyncLen),
        .hBack    (hBack),
        .vActive  (vActive),
        .vFront   (vFront),
        .vSyncLen (vSyncLen),
        .vBack    (vBack)
    ) scan (
        .QClk     (QClk),
        .rstN     (rstN),
        .scanData (scanData),
        .scanAddr (scanAddr),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hSync    (hSync),
        .vSync    (vSync)
    );

endmodule

// ==== sim/mmio_assertions.sv ====
`timescale 1ns/1ps

module mmioAssertions #(
    parameter int hSyncLen = 4
) (
    input logic            QClk,
    input logic            rstN,
    input logic            reqValid,
    input mmioPkg::tOpcode reqOpcode,
    input mmioPkg::tAddr   reqAddress,
    input logic            rspValid,
    input logic            hSync
);
    import mmioPkg::*;

    logic       mapped;
    logic [7:0] lowCnt;  // clocks spent with hSync low

    assign mapped = reqValid && (reqOpcode == opRd || reqOpcode == opWr) &&
                    (reqAddress[23:22] == regionFrame || reqAddress[23:22] == regionCr);

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            lowCnt <= '0;
        end else if (hSync) begin
            lowCnt <= '0;
        end else begin
            lowCnt <= lowCnt + 1'b1;
        end
    end

    // one response per mapped request, exactly three edges on
    rspLatency: assert property (@(posedge QClk) disable iff (!rstN)
        rspValid == $past(mapped, 3))
        else $error("rspValid does not follow a mapped request by three cycles");

    // sync pulse is hSyncLen strobes, two clocks each
    hSyncWidth: assert property (@(posedge QClk) disable iff (!rstN)
        $rose(hSync) |-> lowCnt == 8'(2 * hSyncLen))
        else $error("hSync low time is wrong");

endmodule

bind de10LiteMmio mmioAssertions #(
    .hSyncLen (hSyncLen)
) assertions_i (
    .QClk       (QClk),
    .rstN       (rstN),
    .reqValid   (reqValid),
    .reqOpcode  (reqOpcode),
    .reqAddress (reqAddress),
    .rspValid   (rspValid),
    .hSync      (hSync)
);

// ==== sim/mmioChecker.sv ====
`timescale 1ns/1ps

module mmioChecker (
    input  logic            QClk,
    input  logic            rstN,
    input  logic            rspValid,
    input  mmioPkg::tOpcode rspOpcode,
    input  mmioPkg::tAddr   rspAddress,
    input  mmioPkg::tWord   rspData,
    input  mmioPkg::tSeg    seg0,
    input  mmioPkg::tSeg    seg1,
    input  mmioPkg::tSeg    seg2,
    input  mmioPkg::tSeg    seg3,
    input  mmioPkg::tSeg    seg4,
    input  mmioPkg::tSeg    seg5,
    input  mmioPkg::tLed    led
);
    import mmioPkg::*;

    tAddr expAddrQ [$];  // expected responses, oldest first
    tWord expDataQ [$];
    int   dueQ     [$];  // cycle at which each one must show up
    int   cycle    = 0;
    int   errCount = 0;

    always @(posedge QClk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // called by the testbench when it drives a mapped request
    // --------------------------------------------------
    task automatic expectRsp(input tAddr addr, input tWord data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
        dueQ.push_back(cycle + 3);  // three edges through stages A, B, C
    endtask

    function automatic int pendingCount();
        return dueQ.size();
    endfunction

    task automatic compareField(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (got !== exp) begin
            $display("FAILED %s expected 0x%h got 0x%h", name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkBoard(input logic [41:0] expSegs, input tLed expLed);
        compareField("seg0", 32'(expSegs[6:0]), 32'(seg0));
        compareField("seg1", 32'(expSegs[13:7]), 32'(seg1));
        compareField("seg2", 32'(expSegs[20:14]), 32'(seg2));
        compareField("seg3", 32'(expSegs[27:21]), 32'(seg3));
        compareField("seg4", 32'(expSegs[34:28]), 32'(seg4));
        compareField("seg5", 32'(expSegs[41:35]), 32'(seg5));
        compareField("led", 32'(expLed), 32'(led));
    endtask

    // --------------------------------------------------
    // response port, sampled mid cycle
    // --------------------------------------------------
    always @(negedge QClk) begin
        if (rstN) begin
            if (rspValid) begin
                if (dueQ.size() == 0) begin
                    $display("response arrived with no request outstanding, address 0x%h",
                             rspAddress);
                    errCount++;
                end else begin
                    if (dueQ[0] != cycle) begin
                        $display("response for address 0x%h arrived at the wrong cycle",
                                 rspAddress);
                        errCount++;
                    end
                    compareField("rspOpcode", 32'(opRdRsp), 32'(rspOpcode));
                    compareField("rspAddress", expAddrQ[0], rspAddress);
                    compareField("rspData", expDataQ[0], rspData);
                    void'(expAddrQ.pop_front());
                    void'(expDataQ.pop_front());
                    void'(dueQ.pop_front());
                end
            end else if (dueQ.size() != 0 && dueQ[0] < cycle) begin
                $display("expected response for address 0x%h never arrived", expAddrQ[0]);
                errCount++;
                void'(expAddrQ.pop_front());
                void'(expDataQ.pop_front());
                void'(dueQ.pop_front());
            end
        end
    end

endmodule

// ==== sim/mmioTb.sv ====
`timescale 1ns/1ps

module mmioTb;
    import mmioPkg::*;

    localparam int hActive  = 16;
    localparam int hFront   = 2;
    localparam int hSyncLen = 4;
    localparam int hBack    = 2;
    localparam int vActive  = 8;
    localparam int vFront   = 1;
    localparam int vSyncLen = 2;
    localparam int vBack    = 1;
    localparam int hTotal   = hActive + hFront + hSyncLen + hBack;
    localparam int vTotal   = vActive + vFront + vSyncLen + vBack;
    localparam int words    = hActive * vActive / pixPerWord;
    localparam int timeout  = 2000;  // cycles per wait loop

    logic    QClk;
    logic    rstN;
    logic    reqValid;
    tOpcode  reqOpcode;
    tAddr    reqAddress;
    tWord    reqData;
    logic    button0;
    logic    button1;
    tSwitch  switch;
    logic    rspValid;
    tOpcode  rspOpcode;
    tAddr    rspAddress;
    tWord    rspData;
    tSeg     seg0;
    tSeg     seg1;
    tSeg     seg2;
    tSeg     seg3;
    tSeg     seg4;
    tSeg     seg5;
    tLed     led;
    tColor   red;
    tColor   green;
    tColor   blue;
    logic    hSync;
    logic    vSync;

    tSeg         shadowSeg [6];     // model state
    tLed         shadowLed;
    tWord        shadowFrame [words];
    logic [31:0] rngState;
    int          tbErrors;
    int          fCount;            // clocks of full colour in a line

    de10LiteMmio #(
        .hActive  (hActive),
        .hFront   (hFront),
        .hSyncLen (hSyncLen),
        .hBack    (hBack),
        .vActive  (vActive),
        .vFront   (vFront),
        .vSyncLen (vSyncLen),
        .vBack    (vBack)
    ) dut_i (.*);

    mmioChecker checker_i (.*);

    initial begin
        QClk = 1'b0;
        forever #10 QClk = ~QClk;
    end

    // --------------------------------------------------
    // random numbers and address helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic tAddr crAddr(input logic [19:0] off);
        return {8'h00, regionCr, 2'b00, off};
    endfunction

    function automatic tAddr frameAddr(input int idx);
        return {8'h00, regionFrame, 16'h0000, 4'(idx), 2'b00};
    endfunction

    // reference model returns 1 when the request gets a response
    function automatic logic mmioModel(input tOpcode op, input tAddr addr,
                                       input tWord data, output tWord expData);
        logic [19:0] off;
        int          idx;
        off     = addr[19:0];
        idx     = int'(addr[5:2]);
        expData = '0;
        if (op != opRd && op != opWr) begin
            return 1'b0;
        end
        if (addr[23:22] == regionFrame) begin
            if (op == opWr) shadowFrame[idx] = data;
            else expData = shadowFrame[idx];
            return 1'b1;
        end
        if (addr[23:22] != regionCr) begin
            return 1'b0;  // unmapped region
        end
        if (off < 20'h18 && off[1:0] == 2'b00) begin
            idx = int'(off[4:2]);  // digit number
            if (op == opWr) shadowSeg[idx] = data[6:0];
            else expData = {25'b0, shadowSeg[idx]};
        end else if (off == 20'h18) begin
            if (op == opWr) shadowLed = data[9:0];
            else expData = {22'b0, shadowLed};
        end else if (op == opRd) begin
            if (off == 20'h1C) expData = {31'b0, button0};
            if (off == 20'h20) expData = {31'b0, button1};
            if (off == 20'h24) expData = {22'b0, switch};
        end
        return 1'b1;  // writes to read-only or unknown offsets still answer
    endfunction

    // --------------------------------------------------
    // request driving
    // --------------------------------------------------
    task automatic sendReq(input tOpcode op, input tAddr addr, input tWord data);
        tWord expData;
        logic mapped;
        @(negedge QClk);
        reqValid   = 1'b1;
        reqOpcode  = op;
        reqAddress = addr;
        reqData    = data;
        mapped     = mmioModel(op, addr, data, expData);
        if (mapped) checker_i.expectRsp(addr, expData);
    endtask

    task automatic idle();
        @(negedge QClk);
        reqValid   = 1'b0;
        reqOpcode  = opRd;
        reqAddress = '0;
        reqData    = '0;
    endtask

    // wait for every outstanding response and then check the board
    task automatic drain();
        int n;
        n = 0;
        idle();
        while (checker_i.pendingCount() != 0 && n < timeout) begin
            @(negedge QClk);
            n++;
        end
        if (n >= timeout) begin
            $display("timeout while waiting for outstanding responses");
            tbErrors++;
        end
        repeat (4) @(negedge QClk);  // room for a stray response
        checker_i.checkBoard({shadowSeg[5], shadowSeg[4], shadowSeg[3], shadowSeg[2],
                              shadowSeg[1], shadowSeg[0]}, shadowLed);
    endtask

    // --------------------------------------------------
    // vga helpers
    // --------------------------------------------------
    task automatic waitHSync(input logic level);
        int n;
        n = 0;
        while (hSync !== level && n < timeout) begin
            @(negedge QClk);
            n++;
        end
        if (n >= timeout) begin
            $display("timeout while waiting for hSync to reach %0b", level);
            tbErrors++;
        end
    endtask

    task automatic scanClock();
        @(negedge QClk);
        checker_i.compareField("green", 32'(red), 32'(green));
        checker_i.compareField("blue", 32'(red), 32'(blue));
        if (red === 4'hF) fCount++;
        else checker_i.compareField("red", 32'h0, 32'(red));
    endtask

    // counts clocks of one hSync phase until the level flips
    task automatic countPhase(input logic level, output int n);
        n = 0;
        while (hSync === level && n < timeout) begin
            scanClock();
            n++;
        end
        if (n >= timeout) begin
            $display("hSync stuck at %0b", level);
            tbErrors++;
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int          lowLen;
        int          highLen;
        int          activeLines;
        logic [19:0] off;
        tWord        unused;
        rngState   = 32'h17277ac4;
        tbErrors   = 0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        reqOpcode  = opRd;
        reqAddress = '0;
        reqData    = '0;
        button0    = 1'b0;
        button1    = 1'b0;
        switch     = '0;
        shadowLed  = '0;
        for (int i = 0; i < 6; i++) shadowSeg[i] = '0;
        for (int i = 0; i < words; i++) shadowFrame[i] = '0;

        repeat (10) @(negedge QClk);
        rstN = 1'b1;

        // reset state
        @(negedge QClk);
        checker_i.compareField("rspValid", 32'h0, 32'(rspValid));
        checker_i.compareField("red", 32'h0, 32'(red));
        checker_i.compareField("green", 32'h0, 32'(green));
        checker_i.compareField("blue", 32'h0, 32'(blue));
        checker_i.compareField("hSync", 32'h1, 32'(hSync));
        checker_i.compareField("vSync", 32'h1, 32'(vSync));
        checker_i.checkBoard('0, '0);

        // register round trip with write then read back
        for (int i = 0; i < 24; i++) begin
            off = 20'((randWord() % 7) * 4);
            sendReq(opWr, crAddr(off), randWord());
            sendReq(opRd, crAddr(off), randWord());
        end
        drain();

        // read-only registers and unknown offsets
        for (int i = 0; i < 4; i++) begin
            @(negedge QClk);
            unused  = randWord();
            button0 = unused[0];
            button1 = unused[1];
            switch  = unused[11:2];
            sendReq(opWr, crAddr(20'h1C), randWord());  // ignored
            sendReq(opWr, crAddr(20'h24), randWord());
            sendReq(opRd, crAddr(20'h1C), '0);
            sendReq(opRd, crAddr(20'h20), '0);
            sendReq(opRd, crAddr(20'h24), '0);
            sendReq(opRd, crAddr(20'h28), '0);      // past the last register
            sendReq(opRd, crAddr(20'hFFFFC), '0);
            sendReq(opRd, crAddr(20'h00006), '0);   // misaligned
            drain();
        end

        // back to back frame buffer bursts with one unmapped access each
        for (int i = 0; i < words; i++) sendReq(opWr, frameAddr(i), randWord());
        sendReq(opWr, {8'h00, 2'b00, 22'h000010}, randWord());
        for (int i = 0; i < words; i++) sendReq(opRd, frameAddr(i), '0);
        sendReq(opRd, {8'h00, 2'b11, 22'h000000}, '0);
        drain();

        // all white frame so that every clock shows full colour or black
        for (int i = 0; i < words; i++) sendReq(opWr, frameAddr(i), 32'hFFFFFFFF);
        drain();

        // hsync width and line period
        waitHSync(1'b1);
        waitHSync(1'b0);
        countPhase(1'b0, lowLen);
        countPhase(1'b1, highLen);
        checker_i.compareField("hSync low clocks", 32'(2 * hSyncLen), 32'(lowLen));
        checker_i.compareField("line clocks", 32'(2 * hTotal), 32'(lowLen + highLen));

        // colour per line over two full frames
        activeLines = 0;
        for (int line = 0; line < 2 * vTotal; line++) begin
            fCount = 0;
            countPhase(1'b0, lowLen);
            countPhase(1'b1, highLen);
            if (fCount != 0) begin
                checker_i.compareField("colour clocks", 32'(2 * hActive), 32'(fCount));
                activeLines++;
            end
        end
        checker_i.compareField("active lines", 32'(2 * vActive), 32'(activeLines));

        $display("errors: checker %0d, testbench %0d", checker_i.errCount, tbErrors);
        if (checker_i.errCount + tbErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/mmioPkg.sv
rtl/mmioCtrl.sv
rtl/crRegs.sv
rtl/vgaFrameMem.sv
rtl/vgaScan.sv
rtl/de10LiteMmio.sv
sim/mmio_assertions.sv
sim/mmioChecker.sv
sim/mmioTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mmioTb
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
